//--- Makefile
# Verilator build and run for the dual-clock FIFO testbench

VERILATOR ?= verilator
TOP       ?= afifo_tb
FLIST     ?= afifo.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SRCS    := $(shell grep -v '^+' $(FLIST))
HEADERS := logic/afifo_params.svh
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source, header or the file list changes
$(BIN): $(SRCS) $(HEADERS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR)

# Exit status of the binary is the test result
run: $(BIN) tests/afifo_testdata.txt
	./$(BIN)

clean:
	rm -rf $(BUILD_DIR)

//--- afifo.f
+incdir+logic
logic/afifo_pkg.sv
logic/reset_bridge.sv
logic/wr_ptr_ctrl.sv
logic/rd_ptr_ctrl.sv
logic/dual_clock_ram.sv
logic/afifo_top.sv
tests/afifo_properties.sv
tests/afifo_tb.sv

//--- logic/afifo_params.svh
`ifndef AFIFO_PARAMS_SVH
`define AFIFO_PARAMS_SVH

// ==============================
// FIFO geometry
// ==============================

// RAM address bits, depth is 2**ADDR_W words
`define AFIFO_ADDR_W 4

// ==============================
// Word layout
// ==============================

// Channel tag, upper field of the word
`define AFIFO_TAG_W 4

// Sample payload, lower field of the word
`define AFIFO_PAYLOAD_W 12

`endif

//--- logic/afifo_pkg.sv
`default_nettype none

`include "afifo_params.svh"

package afifo_pkg;

    // ==============================
    // FIFO word and pointer types
    // ==============================

    // Tag sits above payload, 16 bits with default widths
    typedef struct packed {
        logic [`AFIFO_TAG_W-1:0]     tag;      // Channel number
        logic [`AFIFO_PAYLOAD_W-1:0] payload;  // Sample value
    } afifo_word_t;

    // Address plus wrap bit, same type for binary and Gray form
    typedef logic [`AFIFO_ADDR_W:0] afifo_ptr_t;

    // ==============================
    // Reset bridge, read side FSM
    // ==============================
    typedef enum logic [1:0] {
        RST_IDLE    = 2'd0,  // No handshake running
        RST_REQ     = 2'd1,  // Request high, waiting for ack
        RST_RELEASE = 2'd2   // Request low, waiting for ack to fall
    } rst_state_t;

    // Binary to reflected Gray code
    // Used by both pointer controllers
    function automatic afifo_ptr_t bin_to_gray(input afifo_ptr_t bin);
        return bin ^ (bin >> 1);
    endfunction

endpackage

`default_nettype wire

//--- logic/afifo_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "afifo_params.svh"

module afifo_top (
    input  wire                          r_clk,    // Read clock
    input  wire                          r_rst,    // Sync reset, read domain
    input  wire                          w_clk,    // Write clock
    input  wire                          w_write,  // Write strobe
    input  wire  afifo_pkg::afifo_word_t w_data,   // Word in
    output logic                         w_ready,  // Not full
    input  wire                          r_read,   // Read strobe
    output afifo_pkg::afifo_word_t       r_data,   // Head word
    output logic                         r_ready,  // Not empty
    output logic                         rst_done  // Reset handshake finished
);
    import afifo_pkg::*;

    logic                     r_clear;  // Read side clear level
    logic                     w_clear;  // Write side clear level
    afifo_ptr_t               w_gray;   // Write pointer, to read side
    afifo_ptr_t               r_gray;   // Read pointer, to write side
    logic [`AFIFO_ADDR_W-1:0] w_addr;
    logic [`AFIFO_ADDR_W-1:0] r_addr;
    logic                     w_en;     // Accepted write

    // ==============================
    // Reset crossing
    // ==============================
    reset_bridge u_reset_bridge (
        .r_clk    (r_clk),
        .r_rst    (r_rst),
        .w_clk    (w_clk),
        .r_clear  (r_clear),
        .w_clear  (w_clear),
        .rst_done (rst_done)
    );

    // ==============================
    // Pointer controllers
    // ==============================
    wr_ptr_ctrl u_wr_ptr_ctrl (
        .w_clk   (w_clk),
        .w_clear (w_clear),
        .w_write (w_write),
        .r_gray  (r_gray),
        .w_gray  (w_gray),
        .w_addr  (w_addr),
        .w_en    (w_en),
        .w_ready (w_ready)
    );

    rd_ptr_ctrl u_rd_ptr_ctrl (
        .r_clk   (r_clk),
        .r_clear (r_clear),
        .r_read  (r_read),
        .w_gray  (w_gray),
        .r_gray  (r_gray),
        .r_addr  (r_addr),
        .r_ready (r_ready)
    );

    // ==============================
    // Storage
    // ==============================
    dual_clock_ram u_ram (
        .w_clk  (w_clk),
        .w_en   (w_en),
        .w_addr (w_addr),
        .w_data (w_data),
        .r_clk  (r_clk),
        .r_addr (r_addr),
        .r_data (r_data)
    );

endmodule

`default_nettype wire

//--- logic/dual_clock_ram.sv
`timescale 1ns/1ps
`default_nettype none

`include "afifo_params.svh"

module dual_clock_ram (
    input  wire                         w_clk,   // Write port clock
    input  wire                         w_en,    // Write enable
    input  wire [`AFIFO_ADDR_W-1:0]     w_addr,  // Write address
    input  wire  afifo_pkg::afifo_word_t w_data, // Word to store
    input  wire                         r_clk,   // Read port clock
    input  wire [`AFIFO_ADDR_W-1:0]     r_addr,  // Read address
    output afifo_pkg::afifo_word_t      r_data   // Registered read word
);
    import afifo_pkg::*;

    localparam int DEPTH = 1 << `AFIFO_ADDR_W;

    afifo_word_t mem [0:DEPTH-1];  // Storage, block RAM style

    // ==============================
    // Ports
    // ==============================

    // Write port
    always_ff @(posedge w_clk) begin
        if (w_en) begin
            mem[w_addr] <= w_data;
        end
    end

    // Read port, every cycle, output register only
    always_ff @(posedge r_clk) begin
        r_data <= mem[r_addr];
    end

endmodule

`default_nettype wire

//--- logic/rd_ptr_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "afifo_params.svh"

module rd_ptr_ctrl (
    input  wire                         r_clk,    // Read clock
    input  wire                         r_clear,  // Hold pointers at zero
    input  wire                         r_read,   // Read strobe
    input  wire  afifo_pkg::afifo_ptr_t w_gray,   // Write Gray pointer, w_clk domain
    output afifo_pkg::afifo_ptr_t       r_gray,   // Read Gray pointer to write side
    output logic [`AFIFO_ADDR_W-1:0]    r_addr,   // RAM read address
    output logic                        r_ready   // Head word valid on r_data
);
    import afifo_pkg::*;

    afifo_ptr_t r_bin;        // Binary read pointer
    afifo_ptr_t r_bin_next;   // After this cycle's read
    afifo_ptr_t r_gray_next;  // Gray form of r_bin_next
    afifo_ptr_t w_gray_meta;  // Write pointer sync, first stage
    afifo_ptr_t w_gray_sync;  // Write pointer in r_clk
    logic       r_take;       // Accepted read
    logic       r_not_empty;  // Registered not-empty

    // ==============================
    // Pointer arithmetic
    // ==============================
    assign r_take      = r_read & r_ready;
    assign r_bin_next  = r_bin + afifo_ptr_t'(r_take);
    assign r_gray_next = bin_to_gray(r_bin_next);

    // Next pointer as address, RAM output lines up with r_ready
    assign r_addr = r_bin_next[`AFIFO_ADDR_W-1:0];

    // ==============================
    // Registers
    // ==============================
    always_ff @(posedge r_clk) begin
        if (r_clear) begin
            r_bin       <= '0;
            r_gray      <= '0;
            w_gray_meta <= '0;
            w_gray_sync <= '0;
            r_not_empty <= 1'b0;  // Nothing readable while clearing
        end else begin
            r_bin       <= r_bin_next;
            r_gray      <= r_gray_next;  // Crosses to write side
            w_gray_meta <= w_gray;
            w_gray_sync <= w_gray_meta;
            // Words left if pointers differ after this read
            r_not_empty <= (r_gray_next != w_gray_sync);
        end
    end

    assign r_ready = r_not_empty;

endmodule

`default_nettype wire

//--- logic/reset_bridge.sv
`timescale 1ns/1ps
`default_nettype none

module reset_bridge (
    input  wire  r_clk,     // Read clock
    input  wire  r_rst,     // Sync reset, read domain
    input  wire  w_clk,     // Write clock
    output logic r_clear,   // Holds read pointers cleared
    output logic w_clear,   // Holds write pointers cleared
    output logic rst_done   // Single r_clk pulse when the handshake ends
);
    import afifo_pkg::*;

    rst_state_t state;       // Read side handshake state
    logic       r_req;       // Request level, registered before crossing
    logic       r_ack_meta;  // Ack sync, first stage
    logic       r_ack_sync;  // Ack as seen in r_clk
    logic       w_req_meta;  // Request sync, first stage
    logic       w_ack;       // Synchronized request, doubles as ack

    // ==============================
    // Read domain
    // ==============================

    // Ack back into r_clk, two flops
    always_ff @(posedge r_clk) begin
        r_ack_meta <= w_ack;
        r_ack_sync <= r_ack_meta;
    end

    always_ff @(posedge r_clk) begin
        rst_done <= 1'b0;  // Default low, pulse only
        if (r_rst) begin
            // Start or restart the handshake
            state   <= RST_REQ;
            r_req   <= 1'b1;
            r_clear <= 1'b1;  // Rises on the first sampled r_rst
        end else begin
            case (state)
                RST_REQ: begin
                    if (r_ack_sync) begin  // Write side is clearing
                        state <= RST_RELEASE;
                        r_req <= 1'b0;
                    end
                end
                RST_RELEASE: begin
                    if (!r_ack_sync) begin  // Write side released
                        state    <= RST_IDLE;
                        rst_done <= 1'b1;
                    end
                end
                RST_IDLE: begin
                    r_req <= 1'b0;
                end
                default: begin
                    state <= RST_IDLE;  // Unused encoding
                    r_req <= 1'b0;
                end
            endcase
            // Read side stays cleared through the done pulse
            if (rst_done) begin
                r_clear <= 1'b0;
            end
        end
    end

    // ==============================
    // Write domain
    // ==============================

    // Request into w_clk, two flops
    always_ff @(posedge w_clk) begin
        w_req_meta <= r_req;
        w_ack      <= w_req_meta;
    end

    // Clear level and ack are the same synchronized request
    assign w_clear = w_ack;

endmodule

`default_nettype wire

//--- logic/wr_ptr_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "afifo_params.svh"

module wr_ptr_ctrl (
    input  wire                         w_clk,    // Write clock
    input  wire                         w_clear,  // Hold pointers at zero
    input  wire                         w_write,  // Write strobe
    input  wire  afifo_pkg::afifo_ptr_t r_gray,   // Read Gray pointer, r_clk domain
    output afifo_pkg::afifo_ptr_t       w_gray,   // Write Gray pointer to read side
    output logic [`AFIFO_ADDR_W-1:0]    w_addr,   // RAM write address
    output logic                        w_en,     // RAM write enable
    output logic                        w_ready   // Space available
);
    import afifo_pkg::*;

    // Top two bits flipped marks a pointer one lap ahead
    localparam afifo_ptr_t FULL_MASK = {2'b11, {(`AFIFO_ADDR_W-1){1'b0}}};

    afifo_ptr_t w_bin;        // Binary write pointer
    afifo_ptr_t w_bin_next;   // After this cycle's write
    afifo_ptr_t w_gray_next;  // Gray form of w_bin_next
    afifo_ptr_t r_gray_meta;  // Read pointer sync, first stage
    afifo_ptr_t r_gray_sync;  // Read pointer in w_clk
    logic       w_full;       // Registered full, also set while clearing

    // ==============================
    // Pointer arithmetic
    // ==============================
    assign w_en        = w_write & w_ready;  // Accepted write
    assign w_bin_next  = w_bin + afifo_ptr_t'(w_en);
    assign w_gray_next = bin_to_gray(w_bin_next);
    assign w_addr      = w_bin[`AFIFO_ADDR_W-1:0];  // Wrap bit dropped

    // ==============================
    // Registers
    // ==============================
    always_ff @(posedge w_clk) begin
        if (w_clear) begin
            w_bin       <= '0;
            w_gray      <= '0;
            r_gray_meta <= '0;
            r_gray_sync <= '0;
            w_full      <= 1'b1;  // Blocks writes during clear
        end else begin
            w_bin       <= w_bin_next;
            w_gray      <= w_gray_next;  // One bit changes per write
            r_gray_meta <= r_gray;
            r_gray_sync <= r_gray_meta;
            // Full when the next pointer is a whole lap ahead
            w_full      <= (w_gray_next == (r_gray_sync ^ FULL_MASK));
        end
    end

    assign w_ready = ~w_full;

endmodule

`default_nettype wire

//--- tests/afifo_properties.sv
`timescale 1ns/1ps
`default_nettype none

module afifo_properties (
    input wire                          r_clk,
    input wire                          w_clk,
    input wire                          r_rst,
    input wire                          r_clear,
    input wire                          w_clear,
    input wire                          r_ready,
    input wire                          w_ready,
    input wire                          r_read,
    input wire                          rst_done,
    input wire afifo_pkg::afifo_word_t  r_data,
    input wire afifo_pkg::rst_state_t   state     // Bridge FSM, read side
);
    import afifo_pkg::*;

    logic armed = 1'b0;  // Set by the first reset, flags undefined before

    always_ff @(posedge r_clk) begin
        if (r_rst) begin
            armed <= 1'b1;
        end
    end

    // ==============================
    // Read domain
    // ==============================
    a_rclear_blocks_ready: assert property (@(posedge r_clk) disable iff (!armed)
        r_clear |=> !r_ready) else $error("r_ready high while r_clear");

    a_done_one_cycle: assert property (@(posedge r_clk) disable iff (!armed)
        rst_done |=> !rst_done) else $error("rst_done longer than one cycle");

    // Idle goes to request only, never straight to release
    a_no_skip_req: assert property (@(posedge r_clk) disable iff (!armed)
        (state == RST_IDLE) |=> (state != RST_RELEASE)) else $error("bridge skipped RST_REQ");

    a_head_stable: assert property (@(posedge r_clk) disable iff (!armed || r_clear || r_rst)
        (r_ready && !r_read) |=> $stable(r_data)) else $error("r_data moved while held");

    // ==============================
    // Write domain
    // ==============================
    a_wclear_blocks_ready: assert property (@(posedge w_clk) disable iff (!armed)
        w_clear |=> !w_ready) else $error("w_ready high while w_clear");

endmodule

bind afifo_top afifo_properties u_props (
    .r_clk    (r_clk),
    .w_clk    (w_clk),
    .r_rst    (r_rst),
    .r_clear  (r_clear),
    .w_clear  (w_clear),
    .r_ready  (r_ready),
    .w_ready  (w_ready),
    .r_read   (r_read),
    .rst_done (rst_done),
    .r_data   (r_data),
    .state    (u_reset_bridge.state)
);

`default_nettype wire

//--- tests/afifo_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "afifo_params.svh"

module afifo_tb;
    import afifo_pkg::*;

    localparam int DEPTH  = 1 << `AFIFO_ADDR_W;
    localparam int BUDGET = 1500;  // r_clk cycles per command

    typedef enum {OP_WRITE, OP_FILL, OP_READ, OP_DRAIN, OP_RESET, OP_RANDOM} tb_op_t;

    logic r_clk = 1'b0, w_clk = 1'b0;
    logic r_rst = 1'b0, w_write = 1'b0, r_read = 1'b0;
    afifo_word_t w_data = '0;
    afifo_word_t r_data;
    logic w_ready, r_ready, rst_done;

    afifo_word_t model[$];  // Expected FIFO contents, head first
    tb_op_t ops[$];
    int unsigned arg1[$], arg2[$];
    int num_cmds = 0;

    always #4.0 r_clk = ~r_clk;  // 8 ns
    always #5.5 w_clk = ~w_clk;  // 11 ns, drifts against r_clk

    afifo_top UUT (.r_clk(r_clk), .r_rst(r_rst), .w_clk(w_clk), .w_write(w_write),
        .w_data(w_data), .w_ready(w_ready), .r_read(r_read), .r_data(r_data),
        .r_ready(r_ready), .rst_done(rst_done));

    // ==============================
    // Checks
    // ==============================
    task automatic report_failure(input string why);
        $display("%s", why);
        $display("=== FAIL ===");
        $fatal(1, "run stopped");
    endtask

    task automatic check_word(input afifo_word_t got);  // Pops the model head
        afifo_word_t exp;
        if (model.size() == 0) begin
            report_failure("A word was read while the model holds nothing");
        end
        exp = model.pop_front();
        if (got !== exp) begin
            $display("** Error: r_data got %h expected %h", got, exp);
            report_failure("Data mismatch");
        end
    endtask

    task automatic check_count(input int got, input int exp);
        if (got !== exp) begin
            $display("** Error: accepted words got %h expected %h", got, exp);
            report_failure("Count mismatch");
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("** Error: %s got %h expected %h", name, got, exp);
            report_failure("Flag mismatch");
        end
    endtask

    task automatic push_word(input afifo_word_t w);
        model.push_back(w);
        if (model.size() > DEPTH) begin
            report_failure("Model holds more words than the FIFO depth");
        end
    endtask

    // ==============================
    // Drivers
    // ==============================
    task automatic do_reset();
        @(posedge r_clk); #1;
        r_rst = 1'b1;
        model.delete();
        repeat (3) @(posedge r_clk);
        #1 r_rst = 1'b0;
        do @(negedge r_clk); while (rst_done !== 1'b1);
        check_flag("r_ready", r_ready, 1'b0);
        @(negedge w_clk) check_flag("w_ready", w_ready, 1'b1);
        repeat (3) @(negedge r_clk) check_flag("r_ready", r_ready, 1'b0);
    endtask

    task automatic write_word(input afifo_word_t w);
        logic acc;
        acc = 1'b0;
        @(posedge w_clk); #1;
        w_data  = w;
        w_write = 1'b1;
        while (!acc) begin
            @(negedge w_clk) acc = w_ready;  // Value the next edge sees
            @(posedge w_clk); #1;
            if (acc) push_word(w);
        end
        w_write = 1'b0;
    endtask

    task automatic fill();
        int cnt, exp;
        logic acc;
        repeat (8) @(posedge w_clk);  // Let read pointer updates settle
        #1;
        cnt = 0;
        exp = DEPTH - model.size();
        acc = 1'b1;
        w_write = 1'b1;
        while (acc) begin
            w_data = {`AFIFO_TAG_W'(cnt), `AFIFO_PAYLOAD_W'(cnt * 13 + 7)};
            @(negedge w_clk) acc = w_ready;
            @(posedge w_clk); #1;
            if (acc) begin
                push_word(w_data);
                cnt++;
            end
        end
        repeat (3) begin  // Offered while full, must be dropped
            @(negedge w_clk) check_flag("w_ready", w_ready, 1'b0);
            @(posedge w_clk); #1;
        end
        w_write = 1'b0;
        check_count(cnt, exp);
    endtask

    task automatic read_words(input int n, input bit drain);
        int cnt, exp;
        logic more;
        repeat (drain ? 8 : 1) @(posedge r_clk);
        #1;
        cnt    = 0;
        exp    = model.size();  // Words a drain must hand out
        more   = drain || (n > 0);
        r_read = 1'b1;
        while (more) begin
            @(negedge r_clk);
            if (r_ready) begin
                check_word(r_data);
                cnt++;
            end
            more = drain ? r_ready : (cnt < n);  // Drain ends when r_ready falls
            @(posedge r_clk); #1;
        end
        if (drain) begin
            repeat (3) begin  // Strobe on empty changes nothing
                @(negedge r_clk) check_flag("r_ready", r_ready, 1'b0);
                @(posedge r_clk); #1;
            end
        end
        r_read = 1'b0;
        if (drain) begin
            check_count(cnt, exp);
        end
    endtask

    task automatic random_traffic(input int n);
        fork
            begin : writer
                logic acc;
                @(posedge w_clk); #1;
                repeat (n) begin
                    w_write = 1'($urandom % 2);
                    w_data  = afifo_word_t'($urandom % (1 << $bits(afifo_word_t)));
                    @(negedge w_clk) acc = w_write & w_ready;
                    @(posedge w_clk); #1;
                    if (acc) push_word(w_data);
                end
                w_write = 1'b0;
            end
            begin : reader
                @(posedge r_clk); #1;
                repeat (n) begin
                    r_read = 1'($urandom % 2);
                    @(negedge r_clk);
                    if (r_read && r_ready) check_word(r_data);
                    @(posedge r_clk); #1;
                end
                r_read = 1'b0;
            end
        join
    endtask

    // ==============================
    // Command file and main flow
    // ==============================
    task automatic load_commands();
        int fd;
        string line, name;
        int unsigned a, b;
        fd = $fopen("tests/afifo_testdata.txt", "r");
        if (fd == 0) report_failure("Could not open the command file");
        while ($fgets(line, fd) != 0) begin
            a = 0;
            b = 0;
            if (line.len() < 2 || line[0] == "#") continue;  // Blank or comment
            void'($sscanf(line, "%s %h %h", name, a, b));
            case (name)
                "WRITE":  ops.push_back(OP_WRITE);
                "FILL":   ops.push_back(OP_FILL);
                "READ":   ops.push_back(OP_READ);
                "DRAIN":  ops.push_back(OP_DRAIN);
                "RESET":  ops.push_back(OP_RESET);
                "RANDOM": ops.push_back(OP_RANDOM);
                default:  report_failure({"Unknown command in the data file: ", name});
            endcase
            arg1.push_back(a);
            arg2.push_back(b);
        end
        $fclose(fd);
        num_cmds = ops.size();
    endtask

    initial begin : watchdog
        #1;
        repeat ((num_cmds + 1) * BUDGET) @(posedge r_clk);
        report_failure("Timeout, the DUT stopped responding");
    end

    initial begin
        void'($urandom(32'h9e241780));  // One seed for the whole run
        load_commands();
        do_reset();  // Behavior 1 on the power-up reset
        foreach (ops[i]) begin
            case (ops[i])
                OP_WRITE:  write_word({`AFIFO_TAG_W'(arg1[i]), `AFIFO_PAYLOAD_W'(arg2[i])});
                OP_FILL:   fill();
                OP_READ:   read_words(int'(arg1[i]), 1'b0);
                OP_DRAIN:  read_words(0, 1'b1);
                OP_RESET:  do_reset();
                OP_RANDOM: random_traffic(int'(arg1[i]));
            endcase
        end
        $display("=== PASS ===");
        $finish;
    end

endmodule

`default_nettype wire

//--- tests/afifo_testdata.txt
# Columns: opcode, then hex operands
# WRITE tag payload | READ count | RANDOM count | FILL, DRAIN, RESET take none
WRITE 1 abc
WRITE 2 123
WRITE f fff
WRITE 0 000
READ 3
DRAIN
FILL
DRAIN
WRITE 3 555
WRITE 4 aaa
WRITE 7 7e7
RESET
WRITE 5 0f0
WRITE 6 f0f
READ 2
DRAIN
WRITE 8 800
FILL
READ 5
FILL
DRAIN
RANDOM 190
DRAIN
RANDOM 80
DRAIN
